// ==== hdl/bridge_pkg.sv ====
package bridge_pkg;

  //********************************************************************
  // Message word
  //********************************************************************

  // One host or application word
  localparam int MSG_WIDTH = 32;

  typedef logic [MSG_WIDTH-1:0] msg_word_t;

  // All-ones word that closes the inbound data
  localparam msg_word_t END_MARKER = '1;

  //********************************************************************
  // FIFO geometry
  //********************************************************************

  // Same depth for inbound, loopback and outbound
  localparam int FIFO_DEPTH = 16;

  // Pointer and occupancy widths
  localparam int FIFO_AW = $clog2(FIFO_DEPTH);
  localparam int FIFO_CW = $clog2(FIFO_DEPTH + 1);

  // Host sees full two entries early, which leaves room for the
  // write that is already on its way when the flag rises
  localparam int ALMOST_FULL_LEVEL = 14;

  //********************************************************************
  // Stream bundles
  //********************************************************************

  // Host write stream, wren qualifies data
  typedef struct packed {
    logic      wren;
    msg_word_t data;
  } host_wr_t;

  // Application result, valid qualifies data
  typedef struct packed {
    logic      valid;
    msg_word_t data;
  } app_rsp_t;

endpackage

// ==== hdl/host_msg_bridge.sv ====
`timescale 1ns/1ps

module host_msg_bridge (
  input  logic                  bus_clk,
  input  logic                  rst,

  // Host write stream
  input  bridge_pkg::host_wr_t  host_wr,
  output logic                  wr_full,
  input  logic                  wr_open,

  // Host read stream
  input  logic                  rd_rden,
  output bridge_pkg::msg_word_t rd_data,
  output logic                  rd_empty,
  input  logic                  rd_open,
  output logic                  rd_eof,

  // Loopback stream
  input  logic                  loop_rden,
  output bridge_pkg::msg_word_t loop_data,
  output logic                  loop_empty,
  output logic                  loop_eof,

  // Application commands
  output bridge_pkg::msg_word_t pc_msg,
  output logic                  pc_msg_empty,
  input  logic                  pc_msg_ack,

  // Application results
  input  bridge_pkg::app_rsp_t  app_rsp,
  output logic                  fpga_msg_full,
  input  logic                  app_done
);
  import bridge_pkg::*;

  logic in_empty;
  logic loop_full;
  logic out_push;

  //********************************************************************
  // Inbound path, host to application
  //********************************************************************

  // Host stalls on almost full so an in-flight word still fits
  msg_fifo #(
    .AF_LEVEL (ALMOST_FULL_LEVEL)
  ) u_in_fifo (
    .bus_clk     (bus_clk),
    .rst         (rst),
    .wr_en       (host_wr.wren),
    .din         (host_wr.data),
    .rd_en       (pc_msg_ack),
    .dout        (pc_msg),
    .empty       (in_empty),
    .full        (),
    .almost_full (wr_full)
  );

  // Hold off the application while the loopback has no room
  assign pc_msg_empty = in_empty || loop_full;

  //********************************************************************
  // Loopback path
  //********************************************************************

  // Every popped command is copied here for the host to read back
  msg_fifo #(
    .AF_LEVEL (FIFO_DEPTH)
  ) u_loop_fifo (
    .bus_clk     (bus_clk),
    .rst         (rst),
    .wr_en       (pc_msg_ack),
    .din         (pc_msg),
    .rd_en       (loop_rden),
    .dout        (loop_data),
    .empty       (loop_empty),
    .full        (loop_full),
    .almost_full ()
  );

  //********************************************************************
  // Outbound path, application to host
  //********************************************************************

  // Results are dropped while the host has the read stream closed
  assign out_push = app_rsp.valid && rd_open;

  msg_fifo #(
    .AF_LEVEL (FIFO_DEPTH)
  ) u_out_fifo (
    .bus_clk     (bus_clk),
    .rst         (rst),
    .wr_en       (out_push),
    .din         (app_rsp.data),
    .rd_en       (rd_rden),
    .dout        (rd_data),
    .empty       (rd_empty),
    .full        (fpga_msg_full),
    .almost_full ()
  );

  //********************************************************************
  // End of stream
  //********************************************************************

  stream_end_detect u_end_detect (
    .bus_clk    (bus_clk),
    .rst        (rst),
    .in_head    (pc_msg),
    .in_empty   (in_empty),
    .out_empty  (rd_empty),
    .app_done   (app_done),
    .wr_open    (wr_open),
    .loop_empty (loop_empty),
    .rd_eof     (rd_eof),
    .loop_eof   (loop_eof)
  );

  // An ack always lands in the loopback, so no consumed word is lost
  a_ack_has_room : assert property (
    @(posedge bus_clk) disable iff (rst)
    pc_msg_ack |-> (!in_empty && !loop_full)
  ) else $error("host_msg_bridge: ack while loopback full or inbound empty");

endmodule

// ==== hdl/msg_fifo.sv ====
`timescale 1ns/1ps

module msg_fifo #(
  parameter int AF_LEVEL = bridge_pkg::FIFO_DEPTH
) (
  input  logic                  bus_clk,
  input  logic                  rst,
  input  logic                  wr_en,
  input  bridge_pkg::msg_word_t din,
  input  logic                  rd_en,
  output bridge_pkg::msg_word_t dout,
  output logic                  empty,
  output logic                  full,
  output logic                  almost_full
);
  import bridge_pkg::*;

  //********************************************************************
  // Storage and pointers
  //********************************************************************

  msg_word_t mem [FIFO_DEPTH];

  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_CW-1:0] count;

  logic push;
  logic pop;

  // Level must be reachable by the count
  if (AF_LEVEL < 1 || AF_LEVEL > FIFO_DEPTH) begin : g_bad_level
    $error("msg_fifo AF_LEVEL %0d outside 1..%0d", AF_LEVEL, FIFO_DEPTH);
  end

  // Guard the pointers even if a producer misbehaves
  assign push = wr_en && !full;
  assign pop  = rd_en && !empty;

  // Payload array
  always_ff @(posedge bus_clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  // Write side
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      wr_ptr <= '0;
    end else if (push) begin
      if (wr_ptr == FIFO_AW'(FIFO_DEPTH - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // Read side
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (pop) begin
      if (rd_ptr == FIFO_AW'(FIFO_DEPTH - 1)) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy, push and pop together leave it unchanged
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  //********************************************************************
  // Flags and first-word-fall-through output
  //********************************************************************

  // Flags follow the count register, so they move on the count's edge
  assign empty       = (count == '0);
  assign full        = (count == FIFO_CW'(FIFO_DEPTH));
  assign almost_full = (count >= FIFO_CW'(AF_LEVEL));

  // Head word is always visible while not empty
  assign dout = mem[rd_ptr];

  //********************************************************************
  // Checks
  //********************************************************************

  // Producer honours full
  a_no_overflow : assert property (
    @(posedge bus_clk) disable iff (rst)
    wr_en |-> !full
  ) else $error("msg_fifo: write while full");

  // Consumer honours empty
  a_no_underflow : assert property (
    @(posedge bus_clk) disable iff (rst)
    rd_en |-> !empty
  ) else $error("msg_fifo: read while empty");

  // A word pushed into an empty FIFO falls through on the next edge
  a_fall_through : assert property (
    @(posedge bus_clk) disable iff (rst)
    (push && empty) |=> (!empty && dout == $past(din))
  ) else $error("msg_fifo: pushed word did not fall through");

endmodule

// ==== hdl/stream_end_detect.sv ====
`timescale 1ns/1ps

module stream_end_detect (
  input  logic                  bus_clk,
  input  logic                  rst,
  input  bridge_pkg::msg_word_t in_head,
  input  logic                  in_empty,
  input  logic                  out_empty,
  input  logic                  app_done,
  input  logic                  wr_open,
  input  logic                  loop_empty,
  output logic                  rd_eof,
  output logic                  loop_eof
);
  import bridge_pkg::*;

  logic marker_at_head;
  logic rd_eof_next;
  logic loop_eof_next;

  //********************************************************************
  // End conditions
  //********************************************************************

  // Inbound head is the end marker, only meaningful when not empty
  assign marker_at_head = !in_empty && (in_head == END_MARKER);

  // Read stream closes once all results are out, or on request
  assign rd_eof_next = (marker_at_head && out_empty) || app_done;

  // Loopback closes after the host stops writing and the
  // consumed words have all been read back
  assign loop_eof_next = !wr_open && loop_empty;

  //********************************************************************
  // Registered flags
  //********************************************************************

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      rd_eof   <= 1'b0;
      loop_eof <= 1'b0;
    end else begin
      rd_eof   <= rd_eof_next;
      loop_eof <= loop_eof_next;
    end
  end

endmodule

// ==== sources.f ====
hdl/bridge_pkg.sv
hdl/msg_fifo.sv
hdl/stream_end_detect.sv
hdl/host_msg_bridge.sv
verification/bridge_checker.sv
verification/host_msg_bridge_tb.sv

// ==== verification/bridge_checker.sv ====
`timescale 1ns/1ps

module bridge_checker (
  input  logic                  bus_clk,
  input  logic                  rst,
  input  bridge_pkg::host_wr_t  host_wr,
  input  logic                  wr_full,
  input  logic                  wr_open,
  input  logic                  rd_rden,
  input  bridge_pkg::msg_word_t rd_data,
  input  logic                  rd_empty,
  input  logic                  rd_open,
  input  logic                  rd_eof,
  input  logic                  loop_rden,
  input  bridge_pkg::msg_word_t loop_data,
  input  logic                  loop_empty,
  input  logic                  loop_eof,
  input  bridge_pkg::msg_word_t pc_msg,
  input  logic                  pc_msg_empty,
  input  logic                  pc_msg_ack,
  input  bridge_pkg::app_rsp_t  app_rsp,
  input  logic                  fpga_msg_full,
  input  logic                  app_done,
  output int                    value_errs,
  output int                    proto_errs,
  output int                    loop_seen
);
  import bridge_pkg::*;

  // Expected contents of the inbound, loopback and outbound FIFOs
  msg_word_t in_q[$];
  msg_word_t loop_q[$];
  msg_word_t out_q[$];
  msg_word_t scratch;

  // Registered flags, so these hold the previous cycle's condition
  logic exp_rd_eof;
  logic exp_loop_eof;

  logic in_push;
  logic ack_ok;
  logic loop_pop;
  logic out_push;
  logic out_pop;

  //********************************************************************
  // Reference functions
  //********************************************************************

  function automatic logic pc_empty_ref();
    return (in_q.size() == 0) || (loop_q.size() == FIFO_DEPTH);
  endfunction

  function automatic logic rd_end_ref();
    logic marker;
    marker = (in_q.size() != 0) && (in_q[0] == END_MARKER);
    return (marker && out_q.size() == 0) || app_done;
  endfunction

  function automatic logic loop_end_ref();
    return !wr_open && (loop_q.size() == 0);
  endfunction

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
      value_errs = value_errs + 1;
    end
  endtask

  task automatic check_word(input string name, input msg_word_t expected, input msg_word_t actual);
    if (actual !== expected) begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
      value_errs = value_errs + 1;
    end
  endtask

  task automatic flag_protocol(input string what);
    $display("%s at %0t", what, $time);
    proto_errs = proto_errs + 1;
  endtask

  //********************************************************************
  // Compare, then advance the model
  //********************************************************************

  always @(posedge bus_clk) begin
    if (rst) begin
      in_q.delete();
      loop_q.delete();
      out_q.delete();
      exp_rd_eof   = 1'b0;
      exp_loop_eof = 1'b0;
    end else begin
      check_bit("wr_full", in_q.size() >= ALMOST_FULL_LEVEL, wr_full);
      check_bit("pc_msg_empty", pc_empty_ref(), pc_msg_empty);
      check_bit("loop_empty", loop_q.size() == 0, loop_empty);
      check_bit("rd_empty", out_q.size() == 0, rd_empty);
      check_bit("fpga_msg_full", out_q.size() == FIFO_DEPTH, fpga_msg_full);
      check_bit("rd_eof", exp_rd_eof, rd_eof);
      check_bit("loop_eof", exp_loop_eof, loop_eof);
      // Head words only where something is stored
      if (in_q.size() != 0) check_word("pc_msg", in_q[0], pc_msg);
      if (loop_q.size() != 0) check_word("loop_data", loop_q[0], loop_data);
      if (out_q.size() != 0) check_word("rd_data", out_q[0], rd_data);

      if (host_wr.wren && in_q.size() == FIFO_DEPTH) flag_protocol("Host overran the inbound FIFO");
      if (pc_msg_ack && pc_empty_ref()) flag_protocol("Application acked with no command waiting");
      if (loop_rden && loop_q.size() == 0) flag_protocol("Host read an empty loopback FIFO");
      if (rd_rden && out_q.size() == 0) flag_protocol("Host read an empty outbound FIFO");
      if (app_rsp.valid && out_q.size() == FIFO_DEPTH) flag_protocol("Result offered while full");

      exp_rd_eof   = rd_end_ref();
      exp_loop_eof = loop_end_ref();

      in_push  = host_wr.wren && (in_q.size() < FIFO_DEPTH);
      ack_ok   = pc_msg_ack && !pc_empty_ref();
      loop_pop = loop_rden && (loop_q.size() != 0);
      out_push = app_rsp.valid && rd_open && (out_q.size() < FIFO_DEPTH);
      out_pop  = rd_rden && (out_q.size() != 0);

      // Pops first, pushes were judged on the state before the edge
      if (out_pop) scratch = out_q.pop_front();
      if (loop_pop) begin
        scratch   = loop_q.pop_front();
        loop_seen = loop_seen + 1;
      end
      if (ack_ok) begin
        scratch = in_q.pop_front();
        loop_q.push_back(scratch);
      end
      if (in_push) in_q.push_back(host_wr.data);
      if (out_push) out_q.push_back(app_rsp.data);
    end
  end

endmodule

// ==== verification/host_msg_bridge_tb.sv ====
`timescale 1ns/1ps

module host_msg_bridge_tb;
  import bridge_pkg::*;

  //********************************************************************
  // Run parameters
  //********************************************************************

  localparam int          NUM_WORDS      = 200;
  localparam logic [31:0] SEED           = 32'd20586;
  // Roughly ten times the two or three cycles each word needs
  localparam int          TIMEOUT_CYCLES = 20 * NUM_WORDS;
  // Host read stream closed inside this window
  localparam int          CLOSE_START    = 150;
  localparam int          CLOSE_END      = 230;
  localparam int          DONE_PULSE     = 90;
  // Host readers pause here so the loopback and outbound FIFOs fill up
  localparam int          RD_HOLD_START   = 10;
  localparam int          RD_HOLD_END     = 145;
  localparam int          LOOP_HOLD_START = 30;
  localparam int          LOOP_HOLD_END   = 110;
  // Results differ from the commands they answer
  localparam msg_word_t   RSP_MASK       = 32'h5a5a_0f0f;

  logic      bus_clk;
  logic      rst        = 1'b1;
  host_wr_t  host_wr    = '0;
  logic      wr_open    = 1'b1;
  logic      rd_rden    = 1'b0;
  logic      rd_open    = 1'b1;
  logic      loop_rden  = 1'b0;
  logic      pc_msg_ack = 1'b0;
  app_rsp_t  app_rsp    = '0;
  logic      app_done   = 1'b0;

  logic      wr_full;
  msg_word_t rd_data;
  logic      rd_empty;
  logic      rd_eof;
  msg_word_t loop_data;
  logic      loop_empty;
  logic      loop_eof;
  msg_word_t pc_msg;
  logic      pc_msg_empty;
  logic      fpga_msg_full;

  logic      rd_hold;
  logic      loop_hold;

  int value_errs;
  int proto_errs;
  int loop_seen;
  int end_errs = 0;
  int cycle    = 0;
  int sent     = 0;
  int acked    = 0;

  // One generator state per process so draws stay independent
  logic [31:0] host_rng = SEED;
  logic [31:0] app_rng  = SEED ^ 32'h9e37_79b9;
  logic [31:0] rd_rng   = SEED ^ 32'h7f4a_7c15;
  msg_word_t   owed[$];

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Random payload that never collides with the end marker
  function automatic msg_word_t fresh_word(input logic [31:0] r, input int idx);
    msg_word_t w;
    w = {r[15:0], r[31:16]} ^ msg_word_t'(idx);
    if (w == END_MARKER) begin
      w[0] = 1'b0;
    end
    return w;
  endfunction

  host_msg_bridge host_msg_bridge_i (.*);

  bridge_checker bridge_checker_i (.*);

  initial begin
    bus_clk = 1'b0;
    forever #10 bus_clk = ~bus_clk;
  end

  assign rd_hold   = (cycle >= RD_HOLD_START) && (cycle < RD_HOLD_END);
  assign loop_hold = (cycle >= LOOP_HOLD_START) && (cycle < LOOP_HOLD_END);

  //********************************************************************
  // Host side
  //********************************************************************

  // Data words, then the end marker, then the write stream closes
  always @(posedge bus_clk) begin
    host_wr.wren <= 1'b0;
    if (!rst && sent <= NUM_WORDS) begin
      host_rng = lcg_next(host_rng);
      if (!wr_full && host_rng[31:30] != 2'b00) begin
        host_wr.wren <= 1'b1;
        host_wr.data <= (sent == NUM_WORDS) ? END_MARKER : fresh_word(lcg_next(host_rng), sent);
        sent = sent + 1;
      end
    end else if (!rst) begin
      wr_open <= 1'b0;
    end
  end

  // Read and loopback readers, never two pops back to back
  always @(posedge bus_clk) begin
    rd_rden   <= 1'b0;
    loop_rden <= 1'b0;
    if (!rst) begin
      rd_rng = lcg_next(rd_rng);
      if (!rd_rden && !rd_empty && rd_rng[31] && !rd_hold) begin
        rd_rden <= 1'b1;
      end
      if (!loop_rden && !loop_empty && rd_rng[30] && !loop_hold) begin
        loop_rden <= 1'b1;
      end
    end
  end

  //********************************************************************
  // Application side
  //********************************************************************

  always @(posedge bus_clk) begin
    pc_msg_ack    <= 1'b0;
    app_rsp.valid <= 1'b0;
    if (!rst) begin
      app_rng = lcg_next(app_rng);
      // End marker stays at the head to close the read stream
      if (!pc_msg_ack && !pc_msg_empty && pc_msg != END_MARKER && app_rng[31]) begin
        pc_msg_ack <= 1'b1;
        owed.push_back(pc_msg ^ RSP_MASK);
        acked = acked + 1;
      end
      if (!app_rsp.valid && !fpga_msg_full && owed.size() != 0 && app_rng[30]) begin
        app_rsp.valid <= 1'b1;
        app_rsp.data  <= owed.pop_front();
      end
    end
  end

  //********************************************************************
  // Reset, read stream window and timeout
  //********************************************************************

  always @(posedge bus_clk) begin
    cycle <= cycle + 1;
    if (cycle == 1) begin
      rst <= 1'b0;
    end
    rd_open  <= (cycle < CLOSE_START) || (cycle >= CLOSE_END);
    app_done <= (cycle == DONE_PULSE);
    if (cycle == TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    @(negedge rst);
    // Both streams closed, every result handed over and read out
    while (!(rd_eof && loop_eof && rd_empty && !wr_open && acked == NUM_WORDS &&
             owed.size() == 0 && !app_rsp.valid && !pc_msg_ack)) begin
      @(negedge bus_clk);
    end
    repeat (3) @(posedge bus_clk);
    @(negedge bus_clk);
    if (loop_seen != NUM_WORDS) begin
      $display("Only %0d of %0d words came back on the loopback stream", loop_seen, NUM_WORDS);
      end_errs = end_errs + 1;
    end
    $display("Errors: %0d value, %0d protocol, %0d completion",
             value_errs, proto_errs, end_errs);
    if (value_errs + proto_errs + end_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
